// File: rtl/vw_pkg.sv
//----------------------------------------------------------
// virtual-wire index codes, message byte layout and
// transmit FIFO sizing shared by the channel
//----------------------------------------------------------
package vw_pkg;

    // width of an index or a data byte
    localparam int byte_w = 8;

    // index codes of the wire groups handled by the channel
    localparam logic [byte_w-1:0] vw_index_2h  = 8'h02;
    localparam logic [byte_w-1:0] vw_index_3h  = 8'h03;
    localparam logic [byte_w-1:0] vw_index_6h  = 8'h06;
    localparam logic [byte_w-1:0] vw_index_45h = 8'h45;
    localparam logic [byte_w-1:0] vw_index_46h = 8'h46;

    // a message byte carries values in the low nibble and masks above them
    localparam int wires_per_group = 4;
    localparam int mask_lsb        = 4;

    // transmit queue, one entry is data above index
    localparam int fifo_depth = 32;
    localparam int count_w    = 6;
    localparam int entry_w    = 2 * byte_w;

endpackage

// File: rtl/vw_rx_group.sv
//----------------------------------------------------------
// host-to-slave wire group: decode, stage, commit on stop
//----------------------------------------------------------
`timescale 1ns/1ps

module vw_rx_group #(
    parameter logic [vw_pkg::byte_w-1:0] group_index = vw_pkg::vw_index_2h
) (
    input  logic                      clk,
    input  logic                      vw_index_espi_reset_n,
    input  logic                      detect_putvwire,
    input  logic                      spiclk_cnt_done_hl,
    input  logic [2:0]                rx_data_array_cnt,
    input  logic                      malform_vw_packet,
    input  logic                      pec_mismatch,
    input  logic                      vw_channel_en,
    input  logic [vw_pkg::byte_w-1:0] vw_index_byte,
    input  logic [vw_pkg::byte_w-1:0] vw_data_byte,
    input  logic                      stop_det,
    output logic [2:0]                wires
);

    logic       accept;
    logic       index_hit;
    logic [2:0] staged;

    // the data byte of a PUT_VWIRE is complete when the array count reaches one
    assign accept = detect_putvwire && spiclk_cnt_done_hl && (rx_data_array_cnt == 3'h1)
                    && !malform_vw_packet && vw_channel_en;
    assign index_hit = (vw_index_byte == group_index);

    always_ff @(posedge clk or negedge vw_index_espi_reset_n) begin
        if (!vw_index_espi_reset_n) begin
            staged <= '0;
        end else if (accept) begin
            if (index_hit) begin
                // only wires whose mask bit is set take the new value
                for (int i = 0; i < 3; i++) begin
                    if (vw_data_byte[vw_pkg::mask_lsb + i]) begin
                        staged[i] <= vw_data_byte[i];
                    end
                end
            end
        end else if (pec_mismatch) begin
            // a bad PEC throws away whatever was staged since the last commit
            staged <= wires;
        end
    end

    always_ff @(posedge clk or negedge vw_index_espi_reset_n) begin
        if (!vw_index_espi_reset_n) begin
            wires <= '0;
        end else if (stop_det) begin
            wires <= staged;
        end
    end

    // committed wires move only at the edge that follows stop_det
    assert property (@(posedge clk) disable iff (!vw_index_espi_reset_n)
        !$past(stop_det) |-> $stable(wires));

endmodule

// File: rtl/vw_tx_group.sv
//----------------------------------------------------------
// slave-to-host wire group: sampling, change flags and
// the message byte offered to the arbiter
//----------------------------------------------------------
`timescale 1ns/1ps

module vw_tx_group #(
    parameter logic [vw_pkg::wires_per_group-1:0] reset_level = '0
) (
    input  logic                               clk,
    input  logic                               vw_index_espi_reset_n,
    input  logic                               vw_channel_en,
    input  logic [vw_pkg::wires_per_group-1:0] wires_in,
    input  logic                               served,
    output logic                               pending,
    output logic [vw_pkg::byte_w-1:0]          msg_data
);

    logic [vw_pkg::wires_per_group-1:0] sampled;
    logic [vw_pkg::wires_per_group-1:0] changed;

    always_ff @(posedge clk or negedge vw_index_espi_reset_n) begin
        if (!vw_index_espi_reset_n) begin
            sampled <= reset_level;
        end else if (vw_channel_en) begin
            sampled <= wires_in;
        end
    end

    // a fresh difference wins over the served pulse so no edge is lost
    always_ff @(posedge clk or negedge vw_index_espi_reset_n) begin
        if (!vw_index_espi_reset_n) begin
            changed <= '0;
        end else begin
            for (int i = 0; i < vw_pkg::wires_per_group; i++) begin
                if (vw_channel_en && (wires_in[i] != sampled[i])) begin
                    changed[i] <= 1'b1;
                end else if (served) begin
                    changed[i] <= 1'b0;
                end
            end
        end
    end

    assign pending = |changed;

    // mask bits flag the changed wires, values carry every wire's level
    always_comb begin
        msg_data = '0;
        msg_data[vw_pkg::mask_lsb +: vw_pkg::wires_per_group] = changed;
        msg_data[vw_pkg::wires_per_group-1:0] = wires_in;
    end

endmodule

// File: rtl/vw_tx_arbiter.sv
//----------------------------------------------------------
// fixed-priority arbiter over the transmit groups and
// generation of FIFO write strobes
//----------------------------------------------------------
`timescale 1ns/1ps

module vw_tx_arbiter (
    input  logic                      clk,
    input  logic                      vw_index_espi_reset_n,
    input  logic                      pending_6h,
    input  logic                      pending_45h,
    input  logic                      pending_46h,
    input  logic [vw_pkg::byte_w-1:0] data_6h,
    input  logic [vw_pkg::byte_w-1:0] data_45h,
    input  logic [vw_pkg::byte_w-1:0] data_46h,
    output logic                      served_6h,
    output logic                      served_45h,
    output logic                      served_46h,
    output logic                      put,
    output logic [vw_pkg::byte_w-1:0] entry_index,
    output logic [vw_pkg::byte_w-1:0] entry_data
);

    logic mark_6h;
    logic mark_45h;
    logic mark_46h;
    logic sel_6h;
    logic sel_45h;
    logic sel_46h;

    // 6h first, then 45h, then 46h, skipping groups already queued this round
    assign sel_6h  = pending_6h && !mark_6h;
    assign sel_45h = pending_45h && !mark_45h && !sel_6h;
    assign sel_46h = pending_46h && !mark_46h && !sel_6h && !sel_45h;

    // ----------------------------------------------------------
    // round control
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge vw_index_espi_reset_n) begin
        if (!vw_index_espi_reset_n) begin
            put        <= 1'b0;
            served_6h  <= 1'b0;
            served_45h <= 1'b0;
            served_46h <= 1'b0;
            mark_6h    <= 1'b0;
            mark_45h   <= 1'b0;
            mark_46h   <= 1'b0;
        end else begin
            put        <= sel_6h || sel_45h || sel_46h;
            served_6h  <= sel_6h;
            served_45h <= sel_45h;
            served_46h <= sel_46h;
            if (sel_6h || sel_45h || sel_46h) begin
                mark_6h  <= mark_6h || sel_6h;
                mark_45h <= mark_45h || sel_45h;
                mark_46h <= mark_46h || sel_46h;
            end else if (put) begin
                // round is over once the last write leaves with nothing left to pick
                mark_6h  <= 1'b0;
                mark_45h <= 1'b0;
                mark_46h <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------
    // entry registers
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (sel_6h) begin
            entry_index <= vw_pkg::vw_index_6h;
            entry_data  <= data_6h;
        end else if (sel_45h) begin
            entry_index <= vw_pkg::vw_index_45h;
            entry_data  <= data_45h;
        end else if (sel_46h) begin
            entry_index <= vw_pkg::vw_index_46h;
            entry_data  <= data_46h;
        end
    end

    // at most one group is served in any cycle
    assert property (@(posedge clk) disable iff (!vw_index_espi_reset_n)
        $onehot0({served_6h, served_45h, served_46h}));

endmodule

// File: rtl/vw_tx_fifo.sv
//----------------------------------------------------------
// first-word-fall-through queue of index/data entries
//----------------------------------------------------------
`timescale 1ns/1ps

module vw_tx_fifo (
    input  logic                       clk,
    input  logic                       vw_index_espi_reset_n,
    input  logic                       put,
    input  logic [vw_pkg::byte_w-1:0]  entry_index,
    input  logic [vw_pkg::byte_w-1:0]  entry_data,
    input  logic                       pop,
    output logic                       vwire_avail,
    output logic [vw_pkg::byte_w-1:0]  vw_index,
    output logic [vw_pkg::byte_w-1:0]  vw_data,
    output logic [vw_pkg::count_w-1:0] vw_count
);

    logic [vw_pkg::entry_w-1:0]            mem [vw_pkg::fifo_depth];
    logic [$clog2(vw_pkg::fifo_depth)-1:0] wr_ptr;
    logic [$clog2(vw_pkg::fifo_depth)-1:0] rd_ptr;
    logic                                  do_put;
    logic                                  do_pop;

    // writes while full and reads while empty are dropped
    assign do_put = put && (int'(vw_count) != vw_pkg::fifo_depth);
    assign do_pop = pop && vwire_avail;

    always_ff @(posedge clk) begin
        if (do_put) begin
            mem[wr_ptr] <= {entry_data, entry_index};
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge vw_index_espi_reset_n) begin
        if (!vw_index_espi_reset_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            vw_count <= '0;
        end else begin
            if (do_put) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_put, do_pop})
                2'b10:   vw_count <= vw_count + 1'b1;
                2'b01:   vw_count <= vw_count - 1'b1;
                default: vw_count <= vw_count;
            endcase
        end
    end

    assign vwire_avail         = (vw_count != '0);
    assign {vw_data, vw_index} = mem[rd_ptr];

    assert property (@(posedge clk) disable iff (!vw_index_espi_reset_n)
        int'(vw_count) <= vw_pkg::fifo_depth);

    // a pop seen on an empty queue must not move the read side
    assert property (@(posedge clk) disable iff (!vw_index_espi_reset_n)
        (pop && !vwire_avail) |=> $stable(rd_ptr));

endmodule

// File: rtl/vw_channel.sv
//----------------------------------------------------------
// eSPI virtual-wire channel: receive groups 2h/3h, transmit
// groups 6h/45h/46h, arbiter and transmit FIFO
//----------------------------------------------------------
`timescale 1ns/1ps

module vw_channel (
    input  logic                       clk,
    input  logic                       vw_index_espi_reset_n,
    input  logic                       detect_putvwire,
    input  logic                       spiclk_cnt_done_hl,
    input  logic [2:0]                 rx_data_array_cnt,
    input  logic                       malform_vw_packet,
    input  logic                       pec_mismatch,
    input  logic                       stop_det,
    input  logic [vw_pkg::byte_w-1:0]  vw_index_byte,
    input  logic [vw_pkg::byte_w-1:0]  vw_data_byte,
    input  logic                       vw_channel_en,
    input  logic                       sci_n,
    input  logic                       smi_n,
    input  logic                       rcin_n,
    input  logic                       host_rst_ack,
    input  logic [vw_pkg::byte_w-1:0]  ec_to_pch,
    input  logic                       pop_vw_databyte,
    output logic                       slp_s3_n,
    output logic                       slp_s4_n,
    output logic                       slp_s5_n,
    output logic                       sus_stat_n,
    output logic                       pltrst_n,
    output logic                       oob_rst_warn,
    output logic                       vwire_avail,
    output logic [vw_pkg::byte_w-1:0]  vw_index,
    output logic [vw_pkg::byte_w-1:0]  vw_data,
    output logic [vw_pkg::count_w-1:0] vw_count
);

    logic                      pending_6h, pending_45h, pending_46h;
    logic                      served_6h, served_45h, served_46h;
    logic [vw_pkg::byte_w-1:0] data_6h, data_45h, data_46h;
    logic                      put;
    logic [vw_pkg::byte_w-1:0] entry_index;
    logic [vw_pkg::byte_w-1:0] entry_data;

    // ----------------------------------------------------------
    // host to slave
    // ----------------------------------------------------------
    vw_rx_group #(.group_index(vw_pkg::vw_index_2h)) u_rx_2h (
        .clk, .vw_index_espi_reset_n, .detect_putvwire, .spiclk_cnt_done_hl,
        .rx_data_array_cnt, .malform_vw_packet, .pec_mismatch, .vw_channel_en,
        .vw_index_byte, .vw_data_byte, .stop_det,
        .wires ({slp_s5_n, slp_s4_n, slp_s3_n})
    );

    vw_rx_group #(.group_index(vw_pkg::vw_index_3h)) u_rx_3h (
        .clk, .vw_index_espi_reset_n, .detect_putvwire, .spiclk_cnt_done_hl,
        .rx_data_array_cnt, .malform_vw_packet, .pec_mismatch, .vw_channel_en,
        .vw_index_byte, .vw_data_byte, .stop_det,
        .wires ({oob_rst_warn, pltrst_n, sus_stat_n})
    );

    // ----------------------------------------------------------
    // slave to host
    // ----------------------------------------------------------
    // sci_n, smi_n and rcin_n idle high
    vw_tx_group #(.reset_level(4'b0111)) u_tx_6h (
        .clk, .vw_index_espi_reset_n, .vw_channel_en,
        .wires_in ({host_rst_ack, rcin_n, smi_n, sci_n}),
        .served (served_6h), .pending (pending_6h), .msg_data (data_6h)
    );

    vw_tx_group #(.reset_level(4'b0000)) u_tx_45h (
        .clk, .vw_index_espi_reset_n, .vw_channel_en,
        .wires_in (ec_to_pch[3:0]),
        .served (served_45h), .pending (pending_45h), .msg_data (data_45h)
    );

    vw_tx_group #(.reset_level(4'b0000)) u_tx_46h (
        .clk, .vw_index_espi_reset_n, .vw_channel_en,
        .wires_in (ec_to_pch[7:4]),
        .served (served_46h), .pending (pending_46h), .msg_data (data_46h)
    );

    vw_tx_arbiter u_arbiter (
        .clk, .vw_index_espi_reset_n,
        .pending_6h, .pending_45h, .pending_46h, .data_6h, .data_45h, .data_46h,
        .served_6h, .served_45h, .served_46h, .put, .entry_index, .entry_data
    );

    vw_tx_fifo u_fifo (
        .clk, .vw_index_espi_reset_n, .put, .entry_index, .entry_data,
        .pop (pop_vw_databyte), .vwire_avail, .vw_index, .vw_data, .vw_count
    );

endmodule

// File: verification/tb_clock_gen.sv
//----------------------------------------------------------
// free-running testbench clock
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule

// File: verification/tb_vw_channel.sv
//----------------------------------------------------------
// testbench for the virtual-wire channel: stimulus,
// reference model, assertions and watchdog
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_vw_channel;

    // the stimulus needs about 140 cycles and the limit leaves ample margin
    localparam int max_cycles = 300;

    logic                       clk;
    logic                       vw_index_espi_reset_n;
    logic                       detect_putvwire, spiclk_cnt_done_hl, malform_vw_packet;
    logic                       pec_mismatch, stop_det, vw_channel_en, pop_vw_databyte;
    logic [2:0]                 rx_data_array_cnt;
    logic [7:0]                 vw_index_byte, vw_data_byte, ec_to_pch;
    logic                       sci_n, smi_n, rcin_n, host_rst_ack;
    logic                       slp_s3_n, slp_s4_n, slp_s5_n;
    logic                       sus_stat_n, pltrst_n, oob_rst_warn;
    logic                       vwire_avail;
    logic [7:0]                 vw_index, vw_data;
    logic [vw_pkg::count_w-1:0] vw_count;

    // reference model of committed and staged wires and of the transmit queue
    logic [5:0]                 rx_wires;
    logic [5:0]                 exp_rx;
    logic [5:0]                 exp_staged;
    logic [3:0]                 lvl_6h;
    logic [7:0]                 lvl_ec;
    logic [vw_pkg::entry_w-1:0] exp_q[$];
    logic                       settling;
    logic [31:0]                rnd;
    int                         seed;

    tb_clock_gen u_clock_gen (.clk);

    vw_channel u_dut (.*);

    assign rx_wires = {oob_rst_warn, pltrst_n, sus_stat_n, slp_s5_n, slp_s4_n, slp_s3_n};

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("tests failed");
        $fatal(1);
    endtask

    // mask nibble flags the wires that moved, value nibble carries all levels
    function automatic logic [vw_pkg::entry_w-1:0] make_entry(input logic [7:0] index,
            input logic [3:0] old_lvl, input logic [3:0] new_lvl);
        return {old_lvl ^ new_lvl, new_lvl, index};
    endfunction

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------
    assert property (@(posedge clk) disable iff (!vw_index_espi_reset_n) rx_wires == exp_rx)
        else abort_run($sformatf("MISMATCH at %0t: rx wires %b, expected %b",
                                 $time, rx_wires, exp_rx));

    always @(negedge clk) begin
        if (vw_index_espi_reset_n && !settling) begin
            assert (int'(vw_count) == exp_q.size() && vwire_avail == (exp_q.size() != 0))
                else abort_run($sformatf("MISMATCH at %0t: count %0d avail %b, expected %0d",
                                         $time, vw_count, vwire_avail, exp_q.size()));
            if (exp_q.size() != 0) begin
                assert ({vw_data, vw_index} == exp_q[0])
                    else abort_run($sformatf("MISMATCH at %0t: head %h, expected %h",
                                             $time, {vw_data, vw_index}, exp_q[0]));
            end
        end
    end

    // ----------------------------------------------------------
    // stimulus tasks
    // ----------------------------------------------------------
    task automatic send_packet(input logic [7:0] index, input logic [7:0] data,
                               input logic malformed, input logic enabled);
        int base;
        @(posedge clk);
        detect_putvwire    <= 1'b1;
        spiclk_cnt_done_hl <= 1'b1;
        rx_data_array_cnt  <= 3'd1;
        malform_vw_packet  <= malformed;
        vw_channel_en      <= enabled;
        vw_index_byte      <= index;
        vw_data_byte       <= data;
        @(posedge clk);
        detect_putvwire    <= 1'b0;
        spiclk_cnt_done_hl <= 1'b0;
        rx_data_array_cnt  <= 3'd0;
        malform_vw_packet  <= 1'b0;
        vw_channel_en      <= 1'b1;
        // 2h wires sit in the low half of the model, 3h wires above them
        base = (index == vw_pkg::vw_index_3h) ? 3 : 0;
        if (!malformed && enabled
            && (index == vw_pkg::vw_index_2h || index == vw_pkg::vw_index_3h)) begin
            for (int i = 0; i < 3; i++) begin
                if (data[vw_pkg::mask_lsb + i]) begin
                    exp_staged[base + i] = data[i];
                end
            end
        end
        // the staged value has to stay hidden while no stop arrives
        repeat (3) @(posedge clk);
    endtask

    task automatic send_stop();
        @(posedge clk);
        stop_det <= 1'b1;
        @(posedge clk);
        stop_det <= 1'b0;
        exp_rx   <= exp_staged;
        repeat (2) @(posedge clk);
    endtask

    task automatic send_pec_error();
        @(posedge clk);
        pec_mismatch <= 1'b1;
        @(posedge clk);
        pec_mismatch <= 1'b0;
        exp_staged = exp_rx;
    endtask

    task automatic wait_for_count(input int n);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (int'(vw_count) != n) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                abort_run($sformatf("FIFO never reached %0d entries after a wire change", n));
            end
        end
    endtask

    task automatic change_tx(input logic [3:0] new_6h, input logic [7:0] new_ec);
        @(posedge clk);
        {host_rst_ack, rcin_n, smi_n, sci_n} <= new_6h;
        ec_to_pch <= new_ec;
        // entries leave the arbiter in priority order 6h, 45h, 46h
        if (new_6h != lvl_6h) begin
            exp_q.push_back(make_entry(vw_pkg::vw_index_6h, lvl_6h, new_6h));
        end
        if (new_ec[3:0] != lvl_ec[3:0]) begin
            exp_q.push_back(make_entry(vw_pkg::vw_index_45h, lvl_ec[3:0], new_ec[3:0]));
        end
        if (new_ec[7:4] != lvl_ec[7:4]) begin
            exp_q.push_back(make_entry(vw_pkg::vw_index_46h, lvl_ec[7:4], new_ec[7:4]));
        end
        lvl_6h = new_6h;
        lvl_ec = new_ec;
        settling = 1'b1;
        wait_for_count(exp_q.size());
        settling = 1'b0;
    endtask

    task automatic pop_entry();
        @(posedge clk);
        pop_vw_databyte <= 1'b1;
        @(posedge clk);
        pop_vw_databyte <= 1'b0;
        if (exp_q.size() != 0) begin
            void'(exp_q.pop_front());
        end
    endtask

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------
    initial begin
        seed       = 32'hf4b4_e7dc;
        settling   = 1'b0;
        exp_staged = '0;
        lvl_6h     = 4'b0111;
        lvl_ec     = 8'h00;
        vw_index_espi_reset_n <= 1'b0;
        detect_putvwire       <= 1'b0;
        spiclk_cnt_done_hl    <= 1'b0;
        rx_data_array_cnt     <= 3'd0;
        malform_vw_packet     <= 1'b0;
        pec_mismatch          <= 1'b0;
        stop_det              <= 1'b0;
        vw_index_byte         <= 8'h00;
        vw_data_byte          <= 8'h00;
        vw_channel_en         <= 1'b1;
        {host_rst_ack, rcin_n, smi_n, sci_n} <= 4'b0111;
        ec_to_pch             <= 8'h00;
        pop_vw_databyte       <= 1'b0;
        exp_rx                <= '0;
        repeat (3) @(posedge clk);
        vw_index_espi_reset_n <= 1'b1;
        repeat (2) @(posedge clk);

        // masked updates reach the outputs only after stop_det
        send_packet(vw_pkg::vw_index_2h, 8'h57, 1'b0, 1'b1);
        send_stop();
        send_packet(vw_pkg::vw_index_3h, 8'h53, 1'b0, 1'b1);
        send_packet(vw_pkg::vw_index_2h, 8'h32, 1'b0, 1'b1);
        send_stop();

        // malformed, channel off and foreign index leave everything alone
        send_packet(vw_pkg::vw_index_2h, 8'h77, 1'b1, 1'b1);
        send_packet(vw_pkg::vw_index_3h, 8'h77, 1'b0, 1'b0);
        send_packet(8'h04, 8'h77, 1'b0, 1'b1);
        send_stop();
        send_packet(vw_pkg::vw_index_3h, 8'h70, 1'b0, 1'b1);
        send_pec_error();
        send_stop();
        send_packet(vw_pkg::vw_index_3h, 8'h62, 1'b0, 1'b1);
        send_stop();

        // sci_n and rcin_n drop together
        change_tx(4'b0010, lvl_ec);
        pop_entry();

        // host_rst_ack and both ec_to_pch nibbles move in one cycle
        rnd = $random(seed);
        change_tx(4'b1010, lvl_ec ^ {rnd[7:4] | 4'h1, rnd[3:0] | 4'h1});
        repeat (4) pop_entry();

        repeat (4) begin
            rnd = $random(seed);
            change_tx(rnd[3:0], rnd[11:4]);
            pop_entry();
        end
        while (exp_q.size() != 0) begin
            pop_entry();
        end
        pop_entry();
        repeat (2) @(posedge clk);
        $display("all tests passed");
        $finish;
    end

    initial begin
        repeat (max_cycles) @(posedge clk);
        abort_run($sformatf("watchdog expired after %0d cycles, the run is hung", max_cycles));
    end

endmodule

// File: project.f
rtl/vw_pkg.sv
rtl/vw_rx_group.sv
rtl/vw_tx_group.sv
rtl/vw_tx_arbiter.sv
rtl/vw_tx_fifo.sv
rtl/vw_channel.sv
verification/tb_clock_gen.sv
verification/tb_vw_channel.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vw_channel
SEED      ?= 1
FLIST     ?= project.f
BUILD     ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP SEED FLIST BUILD"

test:
	$(VERILATOR) --binary --assert --timing -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	@out=$$(./$(BUILD)/V$(TOP) +verilator+seed+$(SEED)); \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf $(BUILD)
